// File: bench/ipod_cases.txt
// ascii key count period, all fields hex, one test step per line
// ascii 00 is no command, key 0 none, 1 faster, 2 slower, 3 default
45 0 0024 0028
42 0 000A 0028
46 0 0006 0028
00 1 0005 0020
00 1 0004 0018
00 1 0004 0018
00 2 0004 0020
00 2 0004 0028
00 2 0003 0030
00 2 0003 0038
00 2 0003 0040
00 2 0003 0040
00 3 0004 0028
66 0 0004 0028
62 0 0006 0028
44 0 0000 0028
58 0 0000 0028
52 0 0000 0028
65 0 0008 0028
46 0 0006 0028
64 0 0000 0028

// File: verilog.f
rtl/ipod_cfg_pkg.sv
rtl/ipod_cmd_pkg.sv
rtl/flash_fetch_if.sv
rtl/command_decoder.sv
rtl/sample_rate_gen.sv
rtl/flash_reader.sv
rtl/sample_player.sv
rtl/ipod_top.sv
bench/tb_ipod_top.sv

// File: Makefile
# Verilator simulation of the sample playback engine

VERILATOR ?= verilator
TOP       ?= tb_ipod_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# The log decides the result, the testbench prints the pass line only on success
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_ipod_top.sv
`timescale 1ns/1ps

module tb_ipod_top;

  import ipod_cfg_pkg::*;
  import ipod_cmd_pkg::*;

  localparam period_t     SIM_DEFAULT_PERIOD = 16'd40;
  localparam period_t     SIM_PERIOD_STEP    = 16'd8;
  localparam period_t     SIM_MIN_PERIOD     = 16'd24;
  localparam period_t     SIM_MAX_PERIOD     = 16'd64;
  localparam flash_addr_t SIM_LAST_WORD      = 23'd15;
  // Highest sample index with two samples per word
  localparam int          LAST_IDX           = 2 * int'(SIM_LAST_WORD) + 1;
  localparam int          MAX_CASES          = 64;
  localparam int          KEY_LIMIT          = 6;

  logic          CLK_50M;
  logic          rst_n;
  ascii_t        ascii_code;
  logic          ascii_valid;
  logic          key_faster_n;
  logic          key_slower_n;
  logic          key_default_n;
  logic          flash_waitrequest   = 1'b1;
  flash_word_t   flash_readdata      = '0;
  logic          flash_readdatavalid = 1'b0;
  logic          flash_read;
  flash_addr_t   flash_address;
  audio_sample_t sample;
  logic          sample_valid;
  period_t       sample_period;

  logic [15:0] case_mem [0:4*MAX_CASES-1];
  int          cycle_count;
  int          last_cycle;
  int          total_samples;
  int          step_samples;
  int          exp_idx;
  logic [31:0] exp_period;
  logic        playing;
  logic        dir_rev;

  // Flash model state
  integer      seed         = 32'h43a;
  logic [31:0] rnd;
  int          wait_left    = 0;
  int          lat_left     = 0;
  logic        read_seen    = 1'b0;
  logic        accepted     = 1'b0;
  logic        data_pending = 1'b0;
  flash_addr_t read_addr    = '0;
  flash_addr_t pend_addr    = '0;

  ipod_top #(
    .DEFAULT_PERIOD (SIM_DEFAULT_PERIOD),
    .PERIOD_STEP    (SIM_PERIOD_STEP),
    .MIN_PERIOD     (SIM_MIN_PERIOD),
    .MAX_PERIOD     (SIM_MAX_PERIOD),
    .LAST_WORD      (SIM_LAST_WORD)
  ) i_dut (.*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ========================================
  // Flash model
  // ========================================

  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    flash_waitrequest   = 1'b1;
    if (accepted)
    begin
      // Read strobe drops after the accepting edge
      check_value("flash_read", {31'd0, flash_read}, 32'd0);
      accepted = 1'b0;
    end
    if (data_pending)
    begin
      if (lat_left == 0)
      begin
        // Bytes 3 and 1 carry 2a+1 and 2a around random bytes
        rnd = $random(seed);
        flash_readdata      = {pend_addr[6:0], 1'b1, rnd[15:8], pend_addr[6:0], 1'b0, rnd[7:0]};
        flash_readdatavalid = 1'b1;
        data_pending        = 1'b0;
      end
      else
        lat_left = lat_left - 1;
    end
    if (flash_read)
    begin
      if (!read_seen)
      begin
        rnd       = $random(seed);
        wait_left = int'(rnd[7:0]) % 3;
        read_seen = 1'b1;
        read_addr = flash_address;
      end
      else
        check_value("flash_address", {9'd0, flash_address}, {9'd0, read_addr});
      if (wait_left == 0)
      begin
        // Accepted at the next rising edge
        flash_waitrequest = 1'b0;
        rnd          = $random(seed);
        lat_left     = int'(rnd[7:0]) % 4;
        pend_addr    = flash_address;
        data_pending = 1'b1;
        read_seen    = 1'b0;
        accepted     = 1'b1;
      end
      else
        wait_left = wait_left - 1;
    end
  end

  // ========================================
  // Checks and sample monitor
  // ========================================

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
      stop_with_failure($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                                  $time, name, got, expected));
  endtask

  // Sample s of the flash image reads back as s mod 256
  task automatic record_sample();
    check_value("sample", {24'd0, sample}, exp_idx % 256);
    if (step_samples > 0)
      check_value("sample spacing", cycle_count - last_cycle, exp_period);
    if (dir_rev)
      exp_idx = (exp_idx == 0) ? LAST_IDX : exp_idx - 1;
    else
      exp_idx = (exp_idx == LAST_IDX) ? 0 : exp_idx + 1;
    last_cycle = cycle_count;
    step_samples++;
    total_samples++;
  endtask

  task automatic next_cycle();
    @(negedge CLK_50M);
    cycle_count++;
    if (sample_valid === 1'b1)
      record_sample();
  endtask

  // ========================================
  // Stimulus
  // ========================================

  task automatic send_command(input ascii_t code);
    ascii_code  = code;
    ascii_valid = 1'b1;
    next_cycle();
    ascii_valid = 1'b0;
    ascii_code  = '0;
    // Decoder took the code at the edge just passed
    case (code)
      "E", "e": playing = 1'b1;
      "D", "d": playing = 1'b0;
      "F", "f": dir_rev = 1'b0;
      "B", "b": dir_rev = 1'b1;
      "R", "r": exp_idx = 0;
      default: ;
    endcase
  endtask

  task automatic press_key(input int key);
    int waited;
    key_faster_n  = (key != 1);
    key_slower_n  = (key != 2);
    key_default_n = (key != 3);
    next_cycle();
    waited = 1;
    while ({16'd0, sample_period} != exp_period && waited < KEY_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    if ({16'd0, sample_period} != exp_period)
      stop_with_failure("sample_period did not take its new value after a key press");
    key_faster_n  = 1'b1;
    key_slower_n  = 1'b1;
    key_default_n = 1'b1;
    // Release has to pass the synchronizer before the next press
    for (waited = 0; waited < KEY_LIMIT; waited++)
      next_cycle();
  endtask

  task automatic collect_samples(input int n);
    int start;
    int waited;
    step_samples = 0;
    while (step_samples < n)
    begin
      start  = total_samples;
      waited = 0;
      while (total_samples == start && waited < 2 * int'(exp_period) + 32)
      begin
        next_cycle();
        waited++;
      end
      if (total_samples == start)
        stop_with_failure("sample_valid did not arrive within two sample periods");
    end
  endtask

  task automatic expect_silence();
    int start;
    int waited;
    // A tick issued as play fell may still land
    next_cycle();
    start = total_samples;
    for (waited = 0; waited < 3 * int'(exp_period); waited++)
      next_cycle();
    check_value("sample count while paused", total_samples, start);
  endtask

  initial
  begin
    int     i;
    int     base;
    int     key;
    int     count;
    ascii_t code;
    rst_n         = 1'b0;
    ascii_code    = '0;
    ascii_valid   = 1'b0;
    key_faster_n  = 1'b1;
    key_slower_n  = 1'b1;
    key_default_n = 1'b1;
    cycle_count   = 0;
    last_cycle    = 0;
    total_samples = 0;
    step_samples  = 0;
    exp_idx       = 0;
    exp_period    = '0;
    playing       = 1'b0;
    dir_rev       = 1'b0;
    for (i = 0; i < 4 * MAX_CASES; i++)
      case_mem[i] = 16'hFFFF;
    $readmemh("bench/ipod_cases.txt", case_mem);

    repeat (4)
      next_cycle();
    // Outputs held at their reset values
    check_value("flash_read", {31'd0, flash_read}, 32'd0);
    check_value("sample_valid", {31'd0, sample_valid}, 32'd0);
    check_value("sample_period", {16'd0, sample_period}, {16'd0, SIM_DEFAULT_PERIOD});
    rst_n = 1'b1;
    next_cycle();

    i = 0;
    while (i < MAX_CASES && case_mem[4 * i] != 16'hFFFF)
    begin
      base       = 4 * i;
      code       = case_mem[base][7:0];
      key        = int'(case_mem[base + 1]);
      count      = int'(case_mem[base + 2]);
      exp_period = {16'd0, case_mem[base + 3]};
      if (code != 8'h00)
        send_command(code);
      if (key != 0)
        press_key(key);
      check_value("sample_period", {16'd0, sample_period}, exp_period);
      if (count != 0)
        collect_samples(count);
      else if (!playing)
        expect_silence();
      i++;
    end
    if (i == 0)
      stop_with_failure("no test steps were read from bench/ipod_cases.txt");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: rtl/ipod_top.sv
`timescale 1ns/1ps

module ipod_top #(
  parameter ipod_cfg_pkg::period_t     DEFAULT_PERIOD = ipod_cfg_pkg::DEFAULT_PERIOD,
  parameter ipod_cfg_pkg::period_t     PERIOD_STEP    = ipod_cfg_pkg::PERIOD_STEP,
  parameter ipod_cfg_pkg::period_t     MIN_PERIOD     = ipod_cfg_pkg::MIN_PERIOD,
  parameter ipod_cfg_pkg::period_t     MAX_PERIOD     = ipod_cfg_pkg::MAX_PERIOD,
  parameter ipod_cfg_pkg::flash_addr_t LAST_WORD      = ipod_cfg_pkg::LAST_WORD
) (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  ipod_cmd_pkg::ascii_t        ascii_code,
  input  logic                        ascii_valid,
  input  logic                        key_faster_n,
  input  logic                        key_slower_n,
  input  logic                        key_default_n,
  input  logic                        flash_waitrequest,
  input  ipod_cfg_pkg::flash_word_t   flash_readdata,
  input  logic                        flash_readdatavalid,
  output logic                        flash_read,
  output ipod_cfg_pkg::flash_addr_t   flash_address,
  output ipod_cfg_pkg::audio_sample_t sample,
  output logic                        sample_valid,
  output ipod_cfg_pkg::period_t       sample_period
);

  logic play;
  logic reverse;
  logic restart;
  logic tick;

  // Player to flash reader
  flash_fetch_if fetch_if ();

  command_decoder i_decoder (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .play        (play),
    .reverse     (reverse),
    .restart     (restart)
  );

  sample_rate_gen #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD)
  ) i_rate_gen (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .play          (play),
    .key_faster_n  (key_faster_n),
    .key_slower_n  (key_slower_n),
    .key_default_n (key_default_n),
    .tick          (tick),
    .sample_period (sample_period)
  );

  sample_player #(
    .LAST_WORD (LAST_WORD)
  ) i_player (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .tick         (tick),
    .reverse      (reverse),
    .restart      (restart),
    .sample       (sample),
    .sample_valid (sample_valid),
    .fetch        (fetch_if.player)
  );

  flash_reader i_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .fetch               (fetch_if.reader)
  );

endmodule

// File: rtl/sample_player.sv
`timescale 1ns/1ps

module sample_player #(
  parameter ipod_cfg_pkg::flash_addr_t LAST_WORD = ipod_cfg_pkg::LAST_WORD
) (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic                        tick,
  input  logic                        reverse,
  input  logic                        restart,
  output ipod_cfg_pkg::audio_sample_t sample,
  output logic                        sample_valid,
  flash_fetch_if.player               fetch
);

  import ipod_cfg_pkg::*;

  localparam sample_idx_t LAST_IDX = {LAST_WORD, 1'b1};

  sample_idx_t idx;
  sample_idx_t next_idx;
  flash_addr_t cur_word;
  flash_word_t word_buf;
  flash_addr_t word_tag;
  logic        word_valid;
  logic        tick_pend;
  logic        word_hit;
  logic        fill_hit;
  logic        fire;
  flash_word_t src_word;

  // ========================================
  // Hit detection and index stepping
  // ========================================

  assign cur_word = idx[23:1];
  assign word_hit = word_valid && (word_tag == cur_word);
  // Word for the current index arriving right now
  assign fill_hit = fetch.done && (fetch.addr == cur_word);
  assign fire     = (tick || tick_pend) && (word_hit || fill_hit);
  assign src_word = fill_hit ? fetch.data : word_buf;

  // Wraps modulo twice the number of words
  always_comb
  begin
    if (reverse)
      next_idx = (idx == '0) ? LAST_IDX : idx - 1'b1;
    else
      next_idx = (idx == LAST_IDX) ? '0 : idx + 1'b1;
  end

  // ========================================
  // Control state
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      idx          <= '0;
      tick_pend    <= 1'b0;
      sample_valid <= 1'b0;
      word_valid   <= 1'b0;
      fetch.req    <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;

      // Fetch whatever word the current index needs
      if (fetch.req)
      begin
        if (fetch.done)
          fetch.req <= 1'b0;
      end
      else if (!word_hit && !restart)
        fetch.req <= 1'b1;

      if (restart)
      begin
        idx        <= '0;
        tick_pend  <= 1'b0;
        word_valid <= 1'b0;
      end
      else
      begin
        if (fetch.done)
          word_valid <= 1'b1;
        if (fire)
        begin
          sample_valid <= 1'b1;
          idx          <= next_idx;
          tick_pend    <= 1'b0;
        end
        // At most one tick waits for the flash
        else if (tick)
          tick_pend <= 1'b1;
      end
    end
  end

  // Word buffer, fetch address and sample data
  always_ff @(posedge CLK_50M)
  begin
    if (fetch.done)
    begin
      word_buf <= fetch.data;
      word_tag <= fetch.addr;
    end
    if (!fetch.req && !word_hit)
      fetch.addr <= cur_word;
    // Upper byte of the 16-bit half
    if (fire)
      sample <= idx[0] ? audio_sample_t'(src_word[31:24]) : audio_sample_t'(src_word[15:8]);
  end

endmodule

// File: rtl/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                      CLK_50M,
  input  logic                      rst_n,
  input  logic                      flash_waitrequest,
  input  ipod_cfg_pkg::flash_word_t flash_readdata,
  input  logic                      flash_readdatavalid,
  output logic                      flash_read,
  output ipod_cfg_pkg::flash_addr_t flash_address,
  flash_fetch_if.reader             fetch
);

  import ipod_cmd_pkg::*;

  reader_state_t state;

  // Read held until the flash drops waitrequest
  assign flash_read = (state == ISSUE);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      fetch.done <= 1'b0;
    end
    else
    begin
      fetch.done <= 1'b0;
      case (state)
        IDLE:
        begin
          // req is still high in the done cycle
          if (fetch.req && !fetch.done)
            state <= ISSUE;
        end
        ISSUE:
        begin
          if (!flash_waitrequest)
            state <= WAIT_DATA;
        end
        WAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            fetch.done <= 1'b1;
            state      <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE && fetch.req)
      flash_address <= fetch.addr;
    if (state == WAIT_DATA && flash_readdatavalid)
      fetch.data <= flash_readdata;
  end

endmodule

// File: rtl/sample_rate_gen.sv
`timescale 1ns/1ps

module sample_rate_gen #(
  parameter ipod_cfg_pkg::period_t DEFAULT_PERIOD = ipod_cfg_pkg::DEFAULT_PERIOD,
  parameter ipod_cfg_pkg::period_t PERIOD_STEP    = ipod_cfg_pkg::PERIOD_STEP,
  parameter ipod_cfg_pkg::period_t MIN_PERIOD     = ipod_cfg_pkg::MIN_PERIOD,
  parameter ipod_cfg_pkg::period_t MAX_PERIOD     = ipod_cfg_pkg::MAX_PERIOD
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  play,
  input  logic                  key_faster_n,
  input  logic                  key_slower_n,
  input  logic                  key_default_n,
  output logic                  tick,
  output ipod_cfg_pkg::period_t sample_period
);

  import ipod_cfg_pkg::*;

  // Bit 0 faster, bit 1 slower, bit 2 default
  logic [2:0] key_n;
  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic [2:0] key_last;
  logic [2:0] key_press;
  period_t    count;

  assign key_n = {key_default_n, key_slower_n, key_faster_n};

  // ========================================
  // Key synchronizers and press edges
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta  <= 3'b111;
      key_sync  <= 3'b111;
      key_last  <= 3'b111;
      key_press <= 3'b000;
    end
    else
    begin
      key_meta  <= key_n;
      key_sync  <= key_meta;
      key_last  <= key_sync;
      // High to low on the synced key is a press
      key_press <= key_last & ~key_sync;
    end
  end

  // Period register, default key wins over the others
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_period <= DEFAULT_PERIOD;
    else if (key_press[2])
      sample_period <= DEFAULT_PERIOD;
    else if (key_press[0])
    begin
      if (sample_period < MIN_PERIOD + PERIOD_STEP)
        sample_period <= MIN_PERIOD;
      else
        sample_period <= sample_period - PERIOD_STEP;
    end
    else if (key_press[1])
    begin
      if (sample_period > MAX_PERIOD - PERIOD_STEP)
        sample_period <= MAX_PERIOD;
      else
        sample_period <= sample_period + PERIOD_STEP;
    end
  end

  // ========================================
  // Sample tick counter
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else
    begin
      tick <= 1'b0;
      // Held at reload while paused so play restarts a full period
      if (!play)
        count <= sample_period - 1'b1;
      else if (count == '0)
      begin
        tick  <= 1'b1;
        count <= sample_period - 1'b1;
      end
      else
        count <= count - 1'b1;
    end
  end

endmodule

// File: rtl/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  ipod_cmd_pkg::ascii_t ascii_code,
  input  logic                 ascii_valid,
  output logic                 play,
  output logic                 reverse,
  output logic                 restart
);

  import ipod_cmd_pkg::*;

  ascii_t code_uc;

  // Clearing bit 5 maps e/d/f/b/r onto the upper case codes
  assign code_uc = ascii_code & 8'hDF;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      play    <= 1'b0;
      reverse <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (ascii_valid)
      begin
        case (code_uc)
          CMD_PLAY:    play    <= 1'b1;
          CMD_PAUSE:   play    <= 1'b0;
          CMD_FWD:     reverse <= 1'b0;
          CMD_REV:     reverse <= 1'b1;
          CMD_RESTART: restart <= 1'b1;
          // Anything else is not a command
          default:     ;
        endcase
      end
    end
  end

endmodule

// File: rtl/flash_fetch_if.sv
`timescale 1ns/1ps

interface flash_fetch_if;

  import ipod_cfg_pkg::*;

  // One word fetch at a time, addr held until done
  logic        req;
  flash_addr_t addr;
  flash_word_t data;
  logic        done;

  modport player (
    output req,
    output addr,
    input  data,
    input  done
  );

  modport reader (
    input  req,
    input  addr,
    output data,
    output done
  );

endinterface

// File: rtl/ipod_cmd_pkg.sv
package ipod_cmd_pkg;

  // ========================================
  // Keyboard commands
  // ========================================

  typedef logic [7:0] ascii_t;

  // Upper case letters, lower case folds onto these
  localparam ascii_t CMD_PLAY    = 8'h45;
  localparam ascii_t CMD_PAUSE   = 8'h44;
  localparam ascii_t CMD_FWD     = 8'h46;
  localparam ascii_t CMD_REV     = 8'h42;
  localparam ascii_t CMD_RESTART = 8'h52;

  // ========================================
  // Flash reader states
  // ========================================

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_DATA
  } reader_state_t;

endpackage

// File: rtl/ipod_cfg_pkg.sv
package ipod_cfg_pkg;

  // ========================================
  // Widths that carry a meaning
  // ========================================

  // Word address into the flash
  typedef logic [22:0] flash_addr_t;

  // Two 16-bit samples per flash word
  typedef logic [31:0] flash_word_t;

  // Word address times two plus the half
  typedef logic [23:0] sample_idx_t;

  typedef logic signed [7:0] audio_sample_t;

  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;

  // ========================================
  // Default timing of the player
  // ========================================

  // About 22 kHz at 50 MHz
  localparam period_t DEFAULT_PERIOD = 16'd2272;
  localparam period_t PERIOD_STEP    = 16'd100;
  localparam period_t MIN_PERIOD     = 16'd1000;
  localparam period_t MAX_PERIOD     = 16'd6000;

  // Highest word address of the sample area
  localparam flash_addr_t LAST_WORD = 23'h7FFFF;

endpackage
